/* hw/mem_subsys_macros.svh */
`ifndef MEM_SUBSYS_MACROS_SVH
`define MEM_SUBSYS_MACROS_SVH

// ~~~~~~~~~~~~~~~~~~~~
// SRAM window
// ~~~~~~~~~~~~~~~~~~~~

// First byte address decoded by the SRAM.
`define MEM_BASE 32'h8000_0000

// Depth of the SRAM in 32-bit words. Must be a power of two.
`define MEM_WORDS 256

// ~~~~~~~~~~~~~~~~~~~~
// Request queue
// ~~~~~~~~~~~~~~~~~~~~

// Number of queued load/store requests. Must be a power of two.
`define REQ_FIFO_DEPTH 4

`endif

/* hw/mem_subsys_pkg.sv */
package mem_subsys_pkg;

    // Byte address as issued by the core.
    typedef logic [31:0] addr_t;

    // One data word, on the request, response and Wishbone sides.
    typedef logic [31:0] data_t;

    // Byte enables, bit n covers byte lane n.
    typedef logic [3:0] sel_t;

    // ~~~~~~~~~~~~~~~~~~~~
    // Alignment master FSM
    // ~~~~~~~~~~~~~~~~~~~~

    // BEAT_LO addresses the word holding the start address.
    // BEAT_HI is only visited when the access crosses a word boundary.
    typedef enum logic [1:0] {
        IDLE,
        BEAT_LO,
        BEAT_HI,
        RESP
    } align_state_t;

endpackage

/* hw/lsu_req_fifo.sv */
`include "mem_subsys_macros.svh"

module lsu_req_fifo (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  logic                  in_we,
    input  mem_subsys_pkg::addr_t in_addr,
    input  mem_subsys_pkg::data_t in_wdata,
    input  mem_subsys_pkg::sel_t  in_wmask,
    output logic                  out_valid,
    input  logic                  out_ready,
    output logic                  out_we,
    output mem_subsys_pkg::addr_t out_addr,
    output mem_subsys_pkg::data_t out_wdata,
    output mem_subsys_pkg::sel_t  out_wmask
);
    import mem_subsys_pkg::*;

    localparam int DEPTH = `REQ_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam logic [PTR_W:0] FULL_COUNT = DEPTH[PTR_W:0];

    logic  we_q    [DEPTH];
    addr_t addr_q  [DEPTH];
    data_t wdata_q [DEPTH];
    sel_t  wmask_q [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             push;
    logic             pop;

    // A full queue still accepts when the head leaves in the same cycle.
    assign out_valid = (count != '0);
    assign in_ready  = (count != FULL_COUNT) || out_ready;

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    assign out_we    = we_q[rd_ptr];
    assign out_addr  = addr_q[rd_ptr];
    assign out_wdata = wdata_q[rd_ptr];
    assign out_wmask = wmask_q[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            we_q[wr_ptr]    <= in_we;
            addr_q[wr_ptr]  <= in_addr;
            wdata_q[wr_ptr] <= in_wdata;
            wmask_q[wr_ptr] <= in_wmask;
        end
    end

    // Pointers wrap on their own since the depth is a power of two.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* hw/lsu_align_master.sv */
module lsu_align_master (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  req_valid,
    output logic                  req_ready,
    input  logic                  req_we,
    input  mem_subsys_pkg::addr_t req_addr,
    input  mem_subsys_pkg::data_t req_wdata,
    input  mem_subsys_pkg::sel_t  req_wmask,
    output logic                  wb_cyc,
    output logic                  wb_stb,
    output logic                  wb_we,
    output mem_subsys_pkg::addr_t wb_adr,
    output mem_subsys_pkg::sel_t  wb_sel,
    output mem_subsys_pkg::data_t wb_dat_w,
    input  logic                  wb_ack,
    input  logic                  wb_err,
    input  mem_subsys_pkg::data_t wb_dat_r,
    output logic                  rsp_valid,
    output mem_subsys_pkg::data_t rsp_rdata,
    output logic                  rsp_err
);
    import mem_subsys_pkg::*;

    align_state_t state;

    // Request captured at the pop.
    logic       r_we;
    logic [1:0] r_off;
    addr_t      r_word;
    sel_t       r_mask;
    data_t      r_wdata;

    // Words returned by the two beats and the running error flag.
    data_t lo_data;
    data_t hi_data;
    logic  err_acc;

    logic [7:0]  sel_wide;
    logic [63:0] dat_wide;
    logic [63:0] rd_wide;
    logic        two_beats;
    logic        in_beat;
    logic        beat_done;

    // ~~~~~~~~~~~~~~~~~~~~
    // Splitting and merging
    // ~~~~~~~~~~~~~~~~~~~~

    // Shifting into a double-width vector gives both beats at once.
    // The lower half belongs to the start word, the upper half spills
    // into the next word.
    assign sel_wide  = {4'b0000, r_mask} << r_off;
    assign dat_wide  = {32'b0, r_wdata} << {r_off, 3'b000};
    assign two_beats = (r_off != 2'b00);

    // Bytes from the offset upward in the low word, then the high word.
    assign rd_wide   = {hi_data, lo_data} >> {r_off, 3'b000};
    assign rsp_rdata = rd_wide[31:0];
    assign rsp_err   = err_acc;
    assign rsp_valid = (state == RESP);
    assign req_ready = (state == IDLE);

    // ~~~~~~~~~~~~~~~~~~~~
    // Wishbone side
    // ~~~~~~~~~~~~~~~~~~~~

    assign in_beat   = (state == BEAT_LO) || (state == BEAT_HI);
    assign beat_done = wb_ack || wb_err;

    // The slave answers one cycle after strobe, so strobe is low in the
    // answering cycle and cyc stays up across both beats.
    assign wb_cyc   = in_beat;
    assign wb_stb   = in_beat && !beat_done;
    assign wb_we    = r_we;
    assign wb_adr   = (state == BEAT_HI) ? r_word + 32'd4 : r_word;
    assign wb_sel   = (state == BEAT_HI) ? sel_wide[7:4] : sel_wide[3:0];
    assign wb_dat_w = (state == BEAT_HI) ? dat_wide[63:32] : dat_wide[31:0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= IDLE;
            err_acc <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (req_valid) begin
                        state   <= BEAT_LO;
                        err_acc <= 1'b0;
                    end
                end
                BEAT_LO: begin
                    if (beat_done) begin
                        err_acc <= err_acc | wb_err;
                        state   <= two_beats ? BEAT_HI : RESP;
                    end
                end
                BEAT_HI: begin
                    if (beat_done) begin
                        err_acc <= err_acc | wb_err;
                        state   <= RESP;
                    end
                end
                RESP: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (req_ready && req_valid) begin
            r_we    <= req_we;
            r_off   <= req_addr[1:0];
            r_word  <= {req_addr[31:2], 2'b00};
            r_mask  <= req_wmask;
            r_wdata <= req_wdata;
        end
        if ((state == BEAT_LO) && beat_done) begin
            lo_data <= wb_dat_r;
        end
        if ((state == BEAT_HI) && beat_done) begin
            hi_data <= wb_dat_r;
        end
    end

endmodule

/* hw/wb_sram.sv */
`include "mem_subsys_macros.svh"

module wb_sram (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  wb_cyc,
    input  logic                  wb_stb,
    input  logic                  wb_we,
    input  mem_subsys_pkg::addr_t wb_adr,
    input  mem_subsys_pkg::sel_t  wb_sel,
    input  mem_subsys_pkg::data_t wb_dat_w,
    output logic                  wb_ack,
    output logic                  wb_err,
    output mem_subsys_pkg::data_t wb_dat_r
);
    import mem_subsys_pkg::*;

    localparam int    IDX_W     = $clog2(`MEM_WORDS);
    localparam addr_t WIN_BYTES = addr_t'(`MEM_WORDS * 4);

    data_t mem [`MEM_WORDS];

    addr_t            offs;
    logic [IDX_W-1:0] idx;
    logic             in_win;
    logic             req;

    // Below the base the subtraction wraps high, so one compare covers
    // both ends of the window.
    assign offs   = wb_adr - `MEM_BASE;
    assign in_win = (offs < WIN_BYTES);
    assign idx    = offs[IDX_W+1:2];

    // A new transfer is one not already answered in this cycle.
    assign req = wb_cyc && wb_stb && !wb_ack && !wb_err;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_ack <= 1'b0;
            wb_err <= 1'b0;
        end else begin
            wb_ack <= req && in_win;
            wb_err <= req && !in_win;
        end
    end

    always_ff @(posedge clk) begin
        if (req && in_win && wb_we) begin
            for (int b = 0; b < 4; b++) begin
                if (wb_sel[b]) begin
                    mem[idx][8*b +: 8] <= wb_dat_w[8*b +: 8];
                end
            end
        end
    end

    // Writes and errors return zero.
    always_ff @(posedge clk) begin
        if (req) begin
            wb_dat_r <= (in_win && !wb_we) ? mem[idx] : '0;
        end
    end

endmodule

/* hw/mem_subsys_top.sv */
module mem_subsys_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  req_valid,
    output logic                  req_ready,
    input  logic                  req_we,
    input  mem_subsys_pkg::addr_t req_addr,
    input  mem_subsys_pkg::data_t req_wdata,
    input  mem_subsys_pkg::sel_t  req_wmask,
    output logic                  rsp_valid,
    output mem_subsys_pkg::data_t rsp_rdata,
    output logic                  rsp_err
);
    import mem_subsys_pkg::*;

    // ~~~~~~~~~~~~~~~~~~~~
    // Queue to master
    // ~~~~~~~~~~~~~~~~~~~~

    logic  fifo_valid;
    logic  fifo_ready;
    logic  fifo_we;
    addr_t fifo_addr;
    data_t fifo_wdata;
    sel_t  fifo_wmask;

    // ~~~~~~~~~~~~~~~~~~~~
    // Internal Wishbone
    // ~~~~~~~~~~~~~~~~~~~~

    logic  wb_cyc;
    logic  wb_stb;
    logic  wb_we;
    addr_t wb_adr;
    sel_t  wb_sel;
    data_t wb_dat_w;
    logic  wb_ack;
    logic  wb_err;
    data_t wb_dat_r;

    lsu_req_fifo u_req_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (req_valid),
        .in_ready  (req_ready),
        .in_we     (req_we),
        .in_addr   (req_addr),
        .in_wdata  (req_wdata),
        .in_wmask  (req_wmask),
        .out_valid (fifo_valid),
        .out_ready (fifo_ready),
        .out_we    (fifo_we),
        .out_addr  (fifo_addr),
        .out_wdata (fifo_wdata),
        .out_wmask (fifo_wmask)
    );

    lsu_align_master u_align_master (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (fifo_valid),
        .req_ready (fifo_ready),
        .req_we    (fifo_we),
        .req_addr  (fifo_addr),
        .req_wdata (fifo_wdata),
        .req_wmask (fifo_wmask),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_sel    (wb_sel),
        .wb_dat_w  (wb_dat_w),
        .wb_ack    (wb_ack),
        .wb_err    (wb_err),
        .wb_dat_r  (wb_dat_r),
        .rsp_valid (rsp_valid),
        .rsp_rdata (rsp_rdata),
        .rsp_err   (rsp_err)
    );

    wb_sram u_sram (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_sel   (wb_sel),
        .wb_dat_w (wb_dat_w),
        .wb_ack   (wb_ack),
        .wb_err   (wb_err),
        .wb_dat_r (wb_dat_r)
    );

endmodule

/* verification/mem_subsys_tb.sv */
`include "mem_subsys_macros.svh"

module mem_subsys_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import mem_subsys_pkg::*;

    localparam int    N_FILL      = `MEM_WORDS;
    localparam int    N_DIRECTED  = 36;
    localparam int    N_BURST     = 12;
    localparam int    N_RANDOM    = 300;
    localparam int    N_REQS      = N_FILL + N_DIRECTED + N_BURST + N_RANDOM;
    localparam int    CYCLE_LIMIT = N_REQS * 8 + 200;
    localparam addr_t WIN_BYTES   = addr_t'(`MEM_WORDS * 4);
    localparam addr_t WIN_TOP     = `MEM_BASE + WIN_BYTES;

    logic  clk = 1'b0;
    logic  rst_n;
    logic  req_valid;
    logic  req_ready;
    logic  req_we;
    addr_t req_addr;
    data_t req_wdata;
    sel_t  req_wmask;
    logic  rsp_valid;
    data_t rsp_rdata;
    logic  rsp_err;

    // Byte image of the SRAM window, updated as stores are accepted.
    logic [7:0] model_mem [`MEM_WORDS * 4];

    data_t       exp_data_q [$];
    logic        exp_err_q  [$];
    logic [32:0] exp_res;
    data_t       exp_data;
    logic        exp_err;

    int     errors      = 0;
    int     cycle_count = 0;
    logic   saw_full;
    integer seed;

    always #10 clk = ~clk;

    mem_subsys_top dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req_we    (req_we),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .req_wmask (req_wmask),
        .rsp_valid (rsp_valid),
        .rsp_rdata (rsp_rdata),
        .rsp_err   (rsp_err)
    );

    // ~~~~~~~~~~~~~~~~~~~~
    // Reference model
    // ~~~~~~~~~~~~~~~~~~~~

    function automatic logic in_window(addr_t a);
        addr_t rel;
        rel = a - `MEM_BASE;
        return rel < WIN_BYTES;
    endfunction

    function automatic int model_index(addr_t a);
        addr_t rel;
        rel = a - `MEM_BASE;
        return int'(rel);
    endfunction

    function automatic data_t fill_word(addr_t a);
        return (a * 32'h9e37_79b1) ^ 32'h5bd1_e995;
    endfunction

    // Returns {err, rdata}. A second beat exists for any non-zero offset,
    // whatever the mask, so it can raise err on its own.
    function automatic logic [32:0] ref_result(logic we, addr_t addr);
        addr_t lo_word;
        addr_t hi_word;
        addr_t a;
        data_t rdata;
        logic  err;
        lo_word = {addr[31:2], 2'b00};
        hi_word = lo_word + 32'd4;
        err     = !in_window(lo_word) || ((addr[1:0] != 2'b00) && !in_window(hi_word));
        rdata   = '0;
        if (!we) begin
            for (int i = 0; i < 4; i++) begin
                a = addr + addr_t'(i);
                if (in_window(a)) begin
                    rdata[8*i +: 8] = model_mem[model_index(a)];
                end
            end
        end
        return {err, rdata};
    endfunction

    function automatic void apply_store(addr_t addr, data_t wdata, sel_t mask);
        addr_t a;
        for (int i = 0; i < 4; i++) begin
            a = addr + addr_t'(i);
            if (mask[i] && in_window(a)) begin
                model_mem[model_index(a)] = wdata[8*i +: 8];
            end
        end
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~
    // Checks
    // ~~~~~~~~~~~~~~~~~~~~

    task automatic stop_on_error(string why);
        errors++;
        $display("%s", why);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_data(string name, data_t expected, data_t actual);
        if (actual !== expected) begin
            stop_on_error($sformatf("Fail %s expected %h actual %h", name, expected, actual));
        end
    endtask

    task automatic check_flag(string name, logic expected, logic actual);
        if (actual !== expected) begin
            stop_on_error($sformatf("Fail %s expected %h actual %h", name, expected, actual));
        end
    endtask

    // Expected results are taken from the model at the accepting edge.
    always @(posedge clk) begin
        if (rst_n && req_valid && req_ready) begin
            exp_res = ref_result(req_we, req_addr);
            exp_data_q.push_back(exp_res[31:0]);
            exp_err_q.push_back(exp_res[32]);
            if (req_we) begin
                apply_store(req_addr, req_wdata, req_wmask);
            end
        end
        if (rst_n && req_valid && !req_ready) begin
            saw_full = 1'b1;
        end
    end

    always @(posedge clk) begin
        if (rst_n && rsp_valid) begin
            if (exp_data_q.size() == 0) begin
                stop_on_error("A response arrived with no request outstanding");
            end else begin
                exp_data = exp_data_q.pop_front();
                exp_err  = exp_err_q.pop_front();
                check_data("rsp_rdata", exp_data, rsp_rdata);
                check_flag("rsp_err", exp_err, rsp_err);
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            stop_on_error($sformatf("Timeout after %0d cycles, %0d responses still missing",
                                    cycle_count, exp_data_q.size()));
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Stimulus
    // ~~~~~~~~~~~~~~~~~~~~

    // Called just after a rising edge; returns at the edge that accepted the request.
    task automatic send_req(logic we, addr_t addr, data_t wdata, sel_t mask);
        req_valid <= 1'b1;
        req_we    <= we;
        req_addr  <= addr;
        req_wdata <= wdata;
        req_wmask <= mask;
        @(posedge clk);
        while (!req_ready) begin
            @(posedge clk);
        end
    endtask

    task automatic store_req(addr_t addr, data_t wdata, sel_t mask);
        send_req(1'b1, addr, wdata, mask);
    endtask

    task automatic load_req(addr_t addr);
        send_req(1'b0, addr, '0, 4'hf);
    endtask

    task automatic wait_drain();
        req_valid <= 1'b0;
        @(posedge clk);
        while (exp_data_q.size() != 0) begin
            @(posedge clk);
        end
    endtask

    initial begin
        addr_t       a;
        logic [31:0] rnd;
        data_t       wdata_r;

        seed      = 32'he7b3_3859;
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req_we    = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
        req_wmask = '0;
        saw_full  = 1'b0;

        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        repeat (5) begin
            @(posedge clk);
            check_flag("rsp_valid", 1'b0, rsp_valid);
            check_flag("req_ready", 1'b1, req_ready);
        end

        // Fill the whole window so later loads never see unwritten bytes.
        for (int w = 0; w < N_FILL; w++) begin
            a = `MEM_BASE + addr_t'(4 * w);
            store_req(a, fill_word(a), 4'hf);
        end

        store_req(`MEM_BASE + 32'h20, 32'hdead_beef, 4'hf);
        store_req(WIN_TOP - 32'd4, 32'h0bad_f00d, 4'hf);
        load_req(`MEM_BASE);
        load_req(`MEM_BASE + 32'h20);
        load_req(WIN_TOP - 32'd4);
        load_req(`MEM_BASE + 32'h200);
        load_req(`MEM_BASE + 32'h124);
        load_req(`MEM_BASE + 32'h2a8);
        load_req(`MEM_BASE + 32'h04);
        load_req(`MEM_BASE + 32'h3f8);

        // Misaligned accesses, then the two words around each of them.
        for (int off = 1; off < 4; off++) begin
            a = `MEM_BASE + 32'h40 + addr_t'(16 * off + off);
            store_req(a, 32'h1122_3344 + data_t'(off), 4'hf);
            load_req(a);
            store_req(a, 32'ha5c3_e17b, 4'b0101);
            load_req(a);
            load_req({a[31:2], 2'b00});
            load_req({a[31:2], 2'b00} + 32'd4);
        end

        // Outside the window, and straddling both of its edges.
        load_req(`MEM_BASE - 32'd4);
        load_req(32'h0000_0010);
        store_req(32'h1000_0001, 32'hffff_ffff, 4'hf);
        load_req(WIN_TOP);
        store_req(WIN_TOP - 32'd2, 32'hcafe_f00d, 4'hf);
        load_req(WIN_TOP - 32'd2);
        load_req(WIN_TOP - 32'd4);
        load_req(`MEM_BASE - 32'd1);
        wait_drain();

        saw_full = 1'b0;
        for (int k = 0; k < N_BURST; k++) begin
            load_req(`MEM_BASE + 32'h101 + addr_t'(4 * k));
        end
        wait_drain();
        if (!saw_full) begin
            stop_on_error("req_ready never dropped during the back-to-back burst");
        end

        for (int n = 0; n < N_RANDOM; n++) begin
            rnd = $random(seed);
            case (rnd[1:0])
                2'd0:    a = `MEM_BASE - 32'd8 + addr_t'(rnd[6:2]);
                2'd1:    a = WIN_TOP - 32'd16 + addr_t'(rnd[6:2]);
                default: a = `MEM_BASE + addr_t'(rnd[11:2]);
            endcase
            wdata_r = $random(seed);
            send_req(rnd[12], a, wdata_r, rnd[16:13]);
        end
        wait_drain();

        // Any extra response in this window is caught by the compare process.
        repeat (20) @(posedge clk);

        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* mem_subsys_top.f */
+incdir+hw
hw/mem_subsys_pkg.sv
hw/lsu_req_fifo.sv
hw/lsu_align_master.sv
hw/wb_sram.sv
hw/mem_subsys_top.sv
verification/mem_subsys_tb.sv

/* Makefile */
# Simulation of the memory subsystem with Verilator.

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0 -Wno-fatal
TOP       := mem_subsys_tb
FILELIST  := mem_subsys_top.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Everything OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# The verdict comes from the log, so a missing pass line fails the target.
run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
